// File: verification/autotest_tests.txt
// id operand_1 operand_2 expected uut_delay uut_error uut_result
// last line carries a foreign id and ends the session
AABBCCDD 11111111 22222222 33333333 00000005 00000000 33333333
AABBCCDD 01020304 A0B0C0D0 12345678 0000000A 00000000 12345679
AABBCCDD 0000FFFF 00000001 00010000 00000003 00000001 00010000
AABBCCDD DEADBEEF 01234567 CAFEF00D 0000FFFF 00000000 CAFEF00D
AABBCCDD 00000001 00000002 00000003 00000001 00000000 00000003
12345678 00000000 00000000 00000000 00000000 00000000 00000000

// File: files.f
rtl/autotest_pkg.sv
rtl/sd_block_pkg.sv
rtl/vector_loader.sv
rtl/test_runner.sv
rtl/result_writer.sv
rtl/autotest_top.sv
verification/tb_clock.sv
verification/autotest_checker.sv
verification/tb_autotest.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_autotest
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, passes if TEST PASS is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_autotest.sv
// testbench top with sd card model, uut model, stimulus and watchdog
`default_nettype none

module tb_autotest
  import autotest_pkg::*;
;

  localparam logic [31:0] FIRST_BLOCK = 32'h0010_0000;
  localparam int          EXEC_LIMIT  = 256;
  localparam int          MAX_TESTS   = 16;
  localparam int          FIELDS      = 7;

  localparam int ACT_NONE  = 0;
  localparam int ACT_READ  = 1;
  localparam int ACT_OTHER = 2;

  logic        clk;
  logic        rst;
  logic        start = 1'b0;
  logic        spi_busy = 1'b0;
  logic [7:0]  spi_data_out = 8'h00;
  logic        end_uut = 1'b0;
  logic        err_uut = 1'b0;
  logic [31:0] result = 32'h0;
  logic        final_req = 1'b0;
  logic        spi_r_block, spi_r_byte, spi_rst, spi_w_block, spi_w_byte;
  logic [31:0] block_addr;
  logic [7:0]  spi_data_in;
  logic        uut_rst, busy, done;
  logic [31:0] operand_1, operand_2, error_count;
  int          errors, checks;

  logic [31:0] vec [0:MAX_TESTS*FIELDS-1];
  int          nt;
  logic [31:0] rng = 32'd32;
  int          busy_left = 0;
  int          action = ACT_NONE;
  int          rd_idx = 0;
  logic        rd_open = 1'b0;
  logic        wr_open = 1'b0;
  int          run_cnt = 0;

  tb_clock u_clock (.clk(clk), .rst(rst));

  autotest_top #(
    .EXEC_LIMIT  (EXEC_LIMIT),
    .FIRST_BLOCK (FIRST_BLOCK)
  ) u_dut (
    .clk(clk), .rst(rst), .start_i(start),
    .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
    .spi_r_block_o(spi_r_block), .spi_r_byte_o(spi_r_byte), .spi_rst_o(spi_rst),
    .spi_block_addr_o(block_addr), .spi_data_in_o(spi_data_in),
    .spi_w_block_o(spi_w_block), .spi_w_byte_o(spi_w_byte),
    .uut_rst_o(uut_rst), .operand_1_o(operand_1), .operand_2_o(operand_2),
    .end_uut_i(end_uut), .err_uut_i(err_uut), .result_i(result),
    .busy_o(busy), .done_o(done), .error_count_o(error_count)
  );

  autotest_checker #(
    .FIRST_BLOCK (FIRST_BLOCK),
    .EXEC_LIMIT  (EXEC_LIMIT)
  ) u_checker (
    .clk(clk), .rst(rst), .final_check_i(final_req),
    .spi_rst_i(spi_rst), .spi_r_block_i(spi_r_block), .spi_r_byte_i(spi_r_byte),
    .spi_w_block_i(spi_w_block), .spi_w_byte_i(spi_w_byte), .spi_data_in_i(spi_data_in),
    .spi_block_addr_i(block_addr), .uut_rst_i(uut_rst),
    .operand_1_i(operand_1), .operand_2_i(operand_2),
    .end_uut_i(end_uut), .err_uut_i(err_uut), .busy_i(busy), .done_i(done),
    .error_count_i(error_count), .errors_o(errors), .checks_o(checks)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // card contents: record fields, then a pattern over the whole address
  function automatic logic [7:0] card_byte(input int blk, input int idx);
    logic [31:0] a;
    if (blk >= 0 && blk < nt && idx < 16) begin
      if (idx < 4)
        return vec[blk*FIELDS][8*(3-idx) +: 8];
      a = vec[blk*FIELDS + idx/4];
      return a[8*(idx%4) +: 8];
    end
    a = 32'(blk*512 + idx);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
  endfunction

  // sd card model, each command held busy for 1 to 4 cycles
  always @(posedge clk) begin
    int blk;
    #1;
    blk = int'(block_addr - FIRST_BLOCK);
    if (busy_left > 0) begin
      busy_left--;
      if (busy_left == 0) begin
        spi_busy = 1'b0;
        if (action == ACT_READ) begin
          spi_data_out = card_byte(blk, rd_idx);
          rd_idx++;
        end
      end
    end else if (!rst) begin
      action = ACT_NONE;
      if (spi_rst) begin
        action = ACT_OTHER;
      end else if (spi_r_block && !rd_open) begin
        rd_open = 1'b1;
        rd_idx = 0;
        action = ACT_OTHER;
      end else if (spi_r_block && spi_r_byte) begin
        action = ACT_READ;
      end else if (spi_w_block && !wr_open) begin
        wr_open = 1'b1;
        action = ACT_OTHER;
      end else if (spi_w_byte) begin
        action = ACT_OTHER;
      end
      if (!spi_r_block)
        rd_open = 1'b0;
      if (!spi_w_block)
        wr_open = 1'b0;
      if (action != ACT_NONE) begin
        rng = xorshift(rng);
        busy_left = 1 + int'(rng % 32'd4);
        spi_busy = 1'b1;
      end
    end
  end

  // uut model, ends or errors after the line's delay
  always @(posedge clk) begin
    int blk;
    #1;
    blk = int'(block_addr - FIRST_BLOCK);
    if (rst || uut_rst) begin
      run_cnt = 0;
      end_uut = 1'b0;
      err_uut = 1'b0;
      result = (blk >= 0 && blk < nt) ? vec[blk*FIELDS+6] : 32'h0;
    end else if (!end_uut && !err_uut) begin
      run_cnt++;
      if (32'(run_cnt) >= vec[blk*FIELDS+4]) begin
        if (vec[blk*FIELDS+5] != 32'h0)
          err_uut = 1'b1;
        else
          end_uut = 1'b1;
      end
    end
  end

  initial begin
    int k;
    longint timeout;
    for (k = 0; k < MAX_TESTS*FIELDS; k++)
      vec[k] = 32'h0;
    $readmemh("verification/autotest_tests.txt", vec);
    nt = 0;
    while (nt < MAX_TESTS - 1 && vec[nt*FIELDS] == CUT_ID)
      nt++;
    nt++;
    timeout = (longint'(nt) * 5000 + 1000) * 10;
    fork
      begin
        #(timeout);
        $display("watchdog expired at %0t, the session did not finish", $time);
        $display("TEST FAIL");
        $finish;
      end
    join_none
    wait (rst === 1'b0);
    repeat (2) @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    do
      @(posedge clk);
    while (!done);
    // idle time to catch stray commands
    repeat (20) @(posedge clk);
    #1 final_req = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/autotest_checker.sv
// checker for written result blocks, uut operands, error count and session end
`default_nettype none

module autotest_checker
  import autotest_pkg::*;
#(
  parameter logic [31:0] FIRST_BLOCK = 32'h0010_0000,
  parameter int          EXEC_LIMIT  = 256
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         final_check_i,
  input  wire         spi_rst_i,
  input  wire         spi_r_block_i,
  input  wire         spi_r_byte_i,
  input  wire         spi_w_block_i,
  input  wire         spi_w_byte_i,
  input  wire  [7:0]  spi_data_in_i,
  input  wire  [31:0] spi_block_addr_i,
  input  wire         uut_rst_i,
  input  wire  [31:0] operand_1_i,
  input  wire  [31:0] operand_2_i,
  input  wire         end_uut_i,
  input  wire         err_uut_i,
  input  wire         busy_i,
  input  wire         done_i,
  input  wire  [31:0] error_count_i,
  output int          errors_o,
  output int          checks_o
);

  localparam int MAX_TESTS = 16;
  localparam int FIELDS    = 7;

  logic [31:0] vec [0:MAX_TESTS*FIELDS-1];
  int          nt;
  int          expected_errs;
  int          written [0:MAX_TESTS-1];
  int          wr_idx;
  int          done_cnt;
  logic [63:0] run_cnt;
  logic        uut_stopped;
  logic        uut_rst_q;
  logic        busy_q;
  logic        w_block_q;
  logic        w_byte_q;
  logic [7:0]  data_q;
  logic        final_done;

  function automatic logic [7:0] expected_byte(input int t, input int idx);
    logic [31:0] w;
    w = 32'h0;
    if (idx < 4)
      return vec[t*FIELDS][8*(3-idx) +: 8];
    if (idx < 20) begin
      // op1, op2, expected, result in file order except result is field 6
      if (idx < 16)
        w = vec[t*FIELDS + 1 + (idx-4)/4];
      else
        w = vec[t*FIELDS + 6];
      return w[8*(idx%4) +: 8];
    end
    if (idx < 28)
      return run_cnt[8*(idx-20) +: 8];
    return 8'hFF;
  endfunction

  task automatic fail_value(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors_o = errors_o + 1;
  endtask

  initial begin
    int k;
    for (k = 0; k < MAX_TESTS*FIELDS; k++)
      vec[k] = 32'h0;
    for (k = 0; k < MAX_TESTS; k++)
      written[k] = 0;
    $readmemh("verification/autotest_tests.txt", vec);
    nt = 0;
    expected_errs = 0;
    while (nt < MAX_TESTS - 1 && vec[nt*FIELDS] == CUT_ID) begin
      if (vec[nt*FIELDS+6] != vec[nt*FIELDS+3] || vec[nt*FIELDS+5] != 32'h0)
        expected_errs++;
      nt++;
    end
    // wrong-id line closes the set
    nt++;
    errors_o = 0;
    checks_o = 0;
    wr_idx = 0;
    done_cnt = 0;
    run_cnt = 64'h0;
    uut_stopped = 1'b1;
    uut_rst_q = 1'b1;
    busy_q = 1'b0;
    w_block_q = 1'b0;
    w_byte_q = 1'b0;
    data_q = 8'h00;
    final_done = 1'b0;
  end

  always @(posedge clk) begin
    int blk;
    blk = int'(spi_block_addr_i - FIRST_BLOCK);
    if (!rst) begin
      // cycles with the uut out of reset and still running
      if (!uut_rst_i) begin
        if (uut_rst_q) begin
          run_cnt = 64'h0;
          uut_stopped = 1'b0;
        end
        if (!end_uut_i && !err_uut_i)
          run_cnt = run_cnt + 64'd1;
        else
          uut_stopped = 1'b1;
        checks_o++;
        if (blk < 0 || blk >= nt - 1) begin
          $display("uut started on block %0d, which is not a test block", blk);
          errors_o++;
        end else if (operand_1_i != vec[blk*FIELDS+1] || operand_2_i != vec[blk*FIELDS+2]) begin
          fail_value($sformatf("block %0d operands %h %h", blk, operand_1_i, operand_2_i));
        end
      end else if (!uut_rst_q && !uut_stopped) begin
        // a uut that never ends is cut off by the cycle limit
        checks_o++;
        if (run_cnt != 64'(EXEC_LIMIT + 1))
          fail_value($sformatf("run without end lasted %0d cycles, expected %0d",
                               run_cnt, EXEC_LIMIT + 1));
      end

      if (spi_w_block_i && !w_block_q) begin
        wr_idx = 0;
        if (blk < 0 || blk >= nt - 1) begin
          $display("block %0d was written although it is not a test block", blk);
          errors_o++;
        end
      end
      if (spi_w_byte_i && !w_byte_q && blk >= 0 && blk < nt - 1) begin
        checks_o++;
        if (spi_data_in_i !== expected_byte(blk, wr_idx))
          fail_value($sformatf("block %0d byte %0d is %h, expected %h", blk, wr_idx,
                               spi_data_in_i, expected_byte(blk, wr_idx)));
        wr_idx++;
      end
      if (spi_w_byte_i && w_byte_q && spi_data_in_i !== data_q)
        fail_value("write data changed while the byte request was high");
      if (!spi_w_block_i && w_block_q && blk >= 0 && blk < nt - 1) begin
        if (wr_idx != 512) begin
          $display("block %0d was written with %0d bytes instead of 512", blk, wr_idx);
          errors_o++;
        end
        written[blk]++;
      end

      if (done_i) begin
        done_cnt++;
        checks_o++;
        if (busy_i || !busy_q)
          fail_value("busy did not fall with done");
        if (error_count_i != 32'(expected_errs))
          fail_value($sformatf("error count %0d, expected %0d", error_count_i, expected_errs));
      end else if (done_cnt > 0 && (spi_rst_i || spi_r_block_i || spi_r_byte_i ||
                                    spi_w_block_i || spi_w_byte_i)) begin
        $display("an SD command is active after the session ended");
        errors_o++;
      end

      if (final_check_i && !final_done) begin
        final_done = 1'b1;
        if (done_cnt != 1) begin
          $display("done pulsed %0d times instead of once", done_cnt);
          errors_o++;
        end
        for (int t = 0; t < nt - 1; t++) begin
          if (written[t] != 1) begin
            $display("block %0d was written %0d times instead of once", t, written[t]);
            errors_o++;
          end
        end
      end
    end
    uut_rst_q = uut_rst_i;
    busy_q    = busy_i;
    w_block_q = spi_w_block_i;
    w_byte_q  = spi_w_byte_i;
    data_q    = spi_data_in_i;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
// clock and reset generator for the testbench
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/autotest_top.sv
// self-test sequencer top with loader, runner and writer
`default_nettype none

module autotest_top
  import sd_block_pkg::*, autotest_pkg::*;
#(
  parameter int          IN1_BYTES   = 4,
  parameter int          IN2_BYTES   = 4,
  parameter int          OUT_BYTES   = 4,
  parameter int          EXEC_LIMIT  = 256,
  parameter logic [31:0] FIRST_BLOCK = 32'h0010_0000
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_i,
  // sd host
  input  wire                       spi_busy_i,
  input  wire byte_t                spi_data_out_i,
  output logic                      spi_r_block_o,
  output logic                      spi_r_byte_o,
  output logic                      spi_rst_o,
  output logic [BLOCK_ADDR_W-1:0]   spi_block_addr_o,
  output byte_t                     spi_data_in_o,
  output logic                      spi_w_block_o,
  output logic                      spi_w_byte_o,
  // unit under test
  output logic                      uut_rst_o,
  output logic [8*IN1_BYTES-1:0]    operand_1_o,
  output logic [8*IN2_BYTES-1:0]    operand_2_o,
  input  wire                       end_uut_i,
  input  wire                       err_uut_i,
  input  wire  [8*OUT_BYTES-1:0]    result_i,
  // status
  output logic                      busy_o,
  output logic                      done_o,
  output logic [31:0]               error_count_o
);

  logic                   load_start;
  logic                   load_done;
  logic                   write_start;
  logic                   write_done;
  logic [31:0]            id;
  logic [8*OUT_BYTES-1:0] expected;
  logic [8*OUT_BYTES-1:0] result_cap;
  logic [TIME_W-1:0]      exec_cycles;

  vector_loader #(
    .IN1_BYTES (IN1_BYTES),
    .IN2_BYTES (IN2_BYTES),
    .OUT_BYTES (OUT_BYTES)
  ) u_loader (
    .clk            (clk),
    .rst            (rst),
    .load_start_i   (load_start),
    .spi_busy_i     (spi_busy_i),
    .spi_data_out_i (spi_data_out_i),
    .spi_r_block_o  (spi_r_block_o),
    .spi_r_byte_o   (spi_r_byte_o),
    .load_done_o    (load_done),
    .id_o           (id),
    .operand_1_o    (operand_1_o),
    .operand_2_o    (operand_2_o),
    .expected_o     (expected)
  );

  test_runner #(
    .EXEC_LIMIT  (EXEC_LIMIT),
    .FIRST_BLOCK (FIRST_BLOCK),
    .OUT_BYTES   (OUT_BYTES)
  ) u_runner (
    .clk              (clk),
    .rst              (rst),
    .start_i          (start_i),
    .spi_busy_i       (spi_busy_i),
    .spi_rst_o        (spi_rst_o),
    .spi_block_addr_o (spi_block_addr_o),
    .load_start_o     (load_start),
    .load_done_i      (load_done),
    .id_i             (id),
    .expected_i       (expected),
    .write_start_o    (write_start),
    .write_done_i     (write_done),
    .uut_rst_o        (uut_rst_o),
    .end_uut_i        (end_uut_i),
    .err_uut_i        (err_uut_i),
    .result_i         (result_i),
    .result_o         (result_cap),
    .exec_cycles_o    (exec_cycles),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .error_count_o    (error_count_o)
  );

  result_writer #(
    .IN1_BYTES (IN1_BYTES),
    .IN2_BYTES (IN2_BYTES),
    .OUT_BYTES (OUT_BYTES)
  ) u_writer (
    .clk           (clk),
    .rst           (rst),
    .write_start_i (write_start),
    .spi_busy_i    (spi_busy_i),
    .id_i          (id),
    .operand_1_i   (operand_1_o),
    .operand_2_i   (operand_2_o),
    .expected_i    (expected),
    .result_i      (result_cap),
    .exec_cycles_i (exec_cycles),
    .spi_w_block_o (spi_w_block_o),
    .spi_w_byte_o  (spi_w_byte_o),
    .spi_data_in_o (spi_data_in_o),
    .write_done_o  (write_done)
  );

endmodule

`default_nettype wire

// File: rtl/result_writer.sv
// streams one result block to the sd host
`default_nettype none

module result_writer
  import sd_block_pkg::*, autotest_pkg::*;
#(
  parameter int IN1_BYTES = 4,
  parameter int IN2_BYTES = 4,
  parameter int OUT_BYTES = 4
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       write_start_i,
  input  wire                       spi_busy_i,
  input  wire  [31:0]               id_i,
  input  wire  [8*IN1_BYTES-1:0]    operand_1_i,
  input  wire  [8*IN2_BYTES-1:0]    operand_2_i,
  input  wire  [8*OUT_BYTES-1:0]    expected_i,
  input  wire  [8*OUT_BYTES-1:0]    result_i,
  input  wire  [TIME_W-1:0]         exec_cycles_i,
  output logic                      spi_w_block_o,
  output logic                      spi_w_byte_o,
  output byte_t                     spi_data_in_o,
  output logic                      write_done_o
);

  localparam int CNT_W = $clog2(BLOCK_BYTES);

  localparam logic [CNT_W-1:0] OFS_IN1  = CNT_W'(ID_BYTES);
  localparam logic [CNT_W-1:0] OFS_IN2  = CNT_W'(ID_BYTES + IN1_BYTES);
  localparam logic [CNT_W-1:0] OFS_EXP  = CNT_W'(ID_BYTES + IN1_BYTES + IN2_BYTES);
  localparam logic [CNT_W-1:0] OFS_RES  = OFS_EXP + CNT_W'(OUT_BYTES);
  localparam logic [CNT_W-1:0] OFS_TIME = OFS_RES + CNT_W'(OUT_BYTES);
  localparam logic [CNT_W-1:0] OFS_END  = OFS_TIME + CNT_W'(TIME_BYTES);
  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BLOCK_BYTES - 1);

  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_OPEN      = 3'd1;
  localparam logic [2:0] ST_OPEN_WAIT = 3'd2;
  localparam logic [2:0] ST_LOAD      = 3'd3;
  localparam logic [2:0] ST_REQ       = 3'd4;
  localparam logic [2:0] ST_WAIT      = 3'd5;
  localparam logic [2:0] ST_DONE      = 3'd6;

  logic [2:0]       state;
  logic [CNT_W-1:0] byte_cnt;
  byte_t            next_byte;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE:
          if (write_start_i) begin
            state    <= ST_OPEN;
            byte_cnt <= '0;
          end
        ST_OPEN:
          if (spi_busy_i)
            state <= ST_OPEN_WAIT;
        ST_OPEN_WAIT:
          if (!spi_busy_i)
            state <= ST_LOAD;
        ST_LOAD:
          state <= ST_REQ;
        ST_REQ:
          if (spi_busy_i)
            state <= ST_WAIT;
        ST_WAIT:
          if (!spi_busy_i) begin
            if (byte_cnt == LAST_BYTE) begin
              state <= ST_DONE;
            end else begin
              state    <= ST_LOAD;
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        ST_DONE:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // source byte for the current offset
  always_comb begin
    next_byte = FILL_BYTE;
    if (byte_cnt < OFS_IN1)
      next_byte = id_i[8*(OFS_IN1 - 1'b1 - byte_cnt) +: 8];
    else if (byte_cnt < OFS_IN2)
      next_byte = operand_1_i[8*(byte_cnt - OFS_IN1) +: 8];
    else if (byte_cnt < OFS_EXP)
      next_byte = operand_2_i[8*(byte_cnt - OFS_IN2) +: 8];
    else if (byte_cnt < OFS_RES)
      next_byte = expected_i[8*(byte_cnt - OFS_EXP) +: 8];
    else if (byte_cnt < OFS_TIME)
      next_byte = result_i[8*(byte_cnt - OFS_RES) +: 8];
    else if (byte_cnt < OFS_END)
      next_byte = exec_cycles_i[8*(byte_cnt - OFS_TIME) +: 8];
  end

  // loaded before the byte request so data holds while w_byte is up
  always_ff @(posedge clk) begin
    if (state == ST_LOAD)
      spi_data_in_o <= next_byte;
  end

  assign spi_w_block_o = (state != ST_IDLE) && (state != ST_DONE);
  assign spi_w_byte_o  = (state == ST_REQ);
  assign write_done_o  = (state == ST_DONE);

endmodule

`default_nettype wire

// File: rtl/test_runner.sv
// session sequencer with uut run, timeout, compare, block address and error count
`default_nettype none

module test_runner
  import sd_block_pkg::*, autotest_pkg::*;
#(
  parameter int          EXEC_LIMIT  = 256,
  parameter logic [31:0] FIRST_BLOCK = 32'h0010_0000,
  parameter int          OUT_BYTES   = 4
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_i,
  input  wire                       spi_busy_i,
  output logic                      spi_rst_o,
  output logic [BLOCK_ADDR_W-1:0]   spi_block_addr_o,
  output logic                      load_start_o,
  input  wire                       load_done_i,
  input  wire  [31:0]               id_i,
  input  wire  [8*OUT_BYTES-1:0]    expected_i,
  output logic                      write_start_o,
  input  wire                       write_done_i,
  output logic                      uut_rst_o,
  input  wire                       end_uut_i,
  input  wire                       err_uut_i,
  input  wire  [8*OUT_BYTES-1:0]    result_i,
  output logic [8*OUT_BYTES-1:0]    result_o,
  output logic [TIME_W-1:0]         exec_cycles_o,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [31:0]               error_count_o
);

  localparam logic [3:0] ST_IDLE     = 4'd0;
  localparam logic [3:0] ST_SD_RST   = 4'd1;
  localparam logic [3:0] ST_SD_WAIT  = 4'd2;
  localparam logic [3:0] ST_LOAD     = 4'd3;
  localparam logic [3:0] ST_ID_CHECK = 4'd4;
  localparam logic [3:0] ST_RUN      = 4'd5;
  localparam logic [3:0] ST_COMPARE  = 4'd6;
  localparam logic [3:0] ST_WRITE    = 4'd7;
  localparam logic [3:0] ST_NEXT     = 4'd8;

  logic [3:0]              state;
  logic [BLOCK_ADDR_W-1:0] block_addr;
  logic [TIME_W-1:0]       exec_cnt;
  logic [31:0]             err_cnt;
  logic                    busy_q;
  logic                    done_q;
  logic [8*OUT_BYTES-1:0]  result_q;
  logic                    uut_err_q;
  logic                    uut_stop;
  logic                    run_end;

  assign uut_stop = end_uut_i || err_uut_i;
  // timeout hits on the cycle the count reaches EXEC_LIMIT + 1
  assign run_end  = (state == ST_RUN) && (uut_stop || exec_cnt >= TIME_W'(EXEC_LIMIT));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      block_addr <= '0;
      exec_cnt   <= '0;
      err_cnt    <= '0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE:
          if (start_i) begin
            state      <= ST_SD_RST;
            block_addr <= BLOCK_ADDR_W'(FIRST_BLOCK);
            err_cnt    <= '0;
            busy_q     <= 1'b1;
          end
        ST_SD_RST:
          if (spi_busy_i)
            state <= ST_SD_WAIT;
        ST_SD_WAIT:
          if (!spi_busy_i)
            state <= ST_LOAD;
        ST_LOAD: begin
          exec_cnt <= '0;
          state    <= ST_ID_CHECK;
        end
        ST_ID_CHECK:
          if (load_done_i) begin
            if (id_i == CUT_ID) begin
              state <= ST_RUN;
            end else begin
              // foreign block ends the session
              state  <= ST_IDLE;
              busy_q <= 1'b0;
              done_q <= 1'b1;
            end
          end
        ST_RUN: begin
          if (!uut_stop)
            exec_cnt <= exec_cnt + 1'b1;
          if (run_end)
            state <= ST_COMPARE;
        end
        ST_COMPARE: begin
          if (result_q != expected_i || uut_err_q)
            err_cnt <= err_cnt + 1'b1;
          state <= ST_WRITE;
        end
        ST_WRITE:
          if (write_done_i)
            state <= ST_NEXT;
        ST_NEXT: begin
          block_addr <= block_addr + 1'b1;
          state      <= ST_LOAD;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // result and error flag as seen when the run stops
  always_ff @(posedge clk) begin
    if (run_end) begin
      result_q  <= result_i;
      uut_err_q <= err_uut_i;
    end
  end

  assign spi_rst_o        = (state == ST_SD_RST);
  assign spi_block_addr_o = block_addr;
  assign load_start_o     = (state == ST_LOAD);
  assign write_start_o    = (state == ST_COMPARE);
  assign uut_rst_o        = (state != ST_RUN);
  assign result_o         = result_q;
  assign exec_cycles_o    = exec_cnt;
  assign busy_o           = busy_q;
  assign done_o           = done_q;
  assign error_count_o    = err_cnt;

endmodule

`default_nettype wire

// File: rtl/vector_loader.sv
// sd block reader capturing test id, operands and expected result
`default_nettype none

module vector_loader
  import sd_block_pkg::*, autotest_pkg::*;
#(
  parameter int IN1_BYTES = 4,
  parameter int IN2_BYTES = 4,
  parameter int OUT_BYTES = 4
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       load_start_i,
  input  wire                       spi_busy_i,
  input  wire byte_t                spi_data_out_i,
  output logic                      spi_r_block_o,
  output logic                      spi_r_byte_o,
  output logic                      load_done_o,
  output logic [31:0]               id_o,
  output logic [8*IN1_BYTES-1:0]    operand_1_o,
  output logic [8*IN2_BYTES-1:0]    operand_2_o,
  output logic [8*OUT_BYTES-1:0]    expected_o
);

  localparam int CNT_W = $clog2(BLOCK_BYTES);

  // field offsets inside the block
  localparam logic [CNT_W-1:0] OFS_IN1 = CNT_W'(ID_BYTES);
  localparam logic [CNT_W-1:0] OFS_IN2 = CNT_W'(ID_BYTES + IN1_BYTES);
  localparam logic [CNT_W-1:0] OFS_EXP = CNT_W'(ID_BYTES + IN1_BYTES + IN2_BYTES);
  localparam logic [CNT_W-1:0] OFS_END = CNT_W'(ID_BYTES + IN1_BYTES + IN2_BYTES + OUT_BYTES);
  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BLOCK_BYTES - 1);

  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_OPEN      = 3'd1;
  localparam logic [2:0] ST_OPEN_WAIT = 3'd2;
  localparam logic [2:0] ST_REQ       = 3'd3;
  localparam logic [2:0] ST_WAIT      = 3'd4;
  localparam logic [2:0] ST_FINISH    = 3'd5;

  logic [2:0]       state;
  logic [CNT_W-1:0] byte_cnt;
  logic             byte_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE:
          if (load_start_i) begin
            state    <= ST_OPEN;
            byte_cnt <= '0;
          end
        ST_OPEN:
          if (spi_busy_i)
            state <= ST_OPEN_WAIT;
        ST_OPEN_WAIT:
          if (!spi_busy_i)
            state <= ST_REQ;
        ST_REQ:
          if (spi_busy_i)
            state <= ST_WAIT;
        ST_WAIT:
          if (!spi_busy_i) begin
            if (byte_cnt == LAST_BYTE) begin
              state <= ST_FINISH;
            end else begin
              state    <= ST_REQ;
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        ST_FINISH:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // byte is on spi_data_out_i once busy drops
  assign byte_valid = (state == ST_WAIT) && !spi_busy_i;

  always_ff @(posedge clk) begin
    if (load_start_i) begin
      id_o        <= '0;
      operand_1_o <= '0;
      operand_2_o <= '0;
      expected_o  <= '0;
    end else if (byte_valid) begin
      if (byte_cnt < OFS_IN1)
        id_o[8*(OFS_IN1 - 1'b1 - byte_cnt) +: 8] <= spi_data_out_i;
      else if (byte_cnt < OFS_IN2)
        operand_1_o[8*(byte_cnt - OFS_IN1) +: 8] <= spi_data_out_i;
      else if (byte_cnt < OFS_EXP)
        operand_2_o[8*(byte_cnt - OFS_IN2) +: 8] <= spi_data_out_i;
      else if (byte_cnt < OFS_END)
        expected_o[8*(byte_cnt - OFS_EXP) +: 8] <= spi_data_out_i;
    end
  end

  assign spi_r_block_o = (state != ST_IDLE) && (state != ST_FINISH);
  assign spi_r_byte_o  = (state == ST_REQ);
  assign load_done_o   = (state == ST_FINISH);

endmodule

`default_nettype wire

// File: rtl/sd_block_pkg.sv
// sd block geometry, data byte type and fill byte
`default_nettype none

package sd_block_pkg;

  // bytes per sd block
  localparam int BLOCK_BYTES = 512;

  localparam int BLOCK_ADDR_W = 32;

  typedef logic [7:0] byte_t;

  // padding written after the used fields
  localparam byte_t FILL_BYTE = 8'hFF;

endpackage

`default_nettype wire

// File: rtl/autotest_pkg.sv
// test record layout constants and execution time width
`default_nettype none

package autotest_pkg;

  // a block is run as a test only if it carries this id
  localparam logic [31:0] CUT_ID = 32'hAABBCCDD;

  // id field at the start of the record, most significant byte first
  localparam int ID_BYTES = 4;

  // operands, expected value, result and exec time follow, lsb first
  localparam int TIME_BYTES = 8;
  localparam int TIME_W = 8 * TIME_BYTES;

endpackage

`default_nettype wire
